// File: Makefile
# Verilator build and run of the privileged CSR testbench

VERILATOR ?= verilator
TOP       ?= tb_priv_csr
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/priv_csr_properties.sv
`timescale 1ns/1ps
`default_nettype none

module priv_csr_properties
	import csr_pkg::*;
(
	input logic            clk,
	input logic            nrst,
	input logic            exception_pending,
	input logic            m_ret,
	input logic            s_ret,
	input mode_t           current_mode,
	input logic            irq_request,
	input logic [XLEN-1:0] mie
);

	int fail_count = 0;

	// first edge after reset release still sees the reset state
	reset_state: assert property (@(posedge clk)
			$rose(nrst) |-> (current_mode == M) && !irq_request)
	else
	begin
		fail_count++;
		$error("mode or interrupt request wrong after reset");
	end

	mode_change: assert property (@(posedge clk) disable iff (!nrst)
			(current_mode != $past(current_mode)) |-> $past(exception_pending || m_ret || s_ret))
	else
	begin
		fail_count++;
		$error("mode changed without a trap or return in the cycle before");
	end

	irq_needs_enable: assert property (@(posedge clk) disable iff (!nrst)
			irq_request |-> (mie != '0))
	else
	begin
		fail_count++;
		$error("interrupt requested with every mie bit clear");
	end

endmodule

`default_nettype wire

// File: bench/tb_priv_csr.sv
`timescale 1ns/1ps
`default_nettype none

module tb_priv_csr
	import csr_pkg::*;
();

	localparam int TEST_CYCLES = 200; // rough length of the whole run
	localparam int MAX_CYCLES  = 10 * TEST_CYCLES;
	localparam int TIMER_AHEAD = 150; // compare distance for the timer test
	localparam int IRQ_WAIT    = TIMER_AHEAD + 50;

	logic            clk;
	logic            nrst;
	csr_op_t         csr_op;
	logic [11:0]     csr_addr;
	logic [XLEN-1:0] csr_src;
	logic            exception_pending;
	logic [XLEN-1:0] cause;
	logic [XLEN-1:0] pc_exc;
	logic            m_ret;
	logic            s_ret;
	logic            ext_m_irq;
	logic            ext_s_irq;
	logic [XLEN-1:0] csr_rdata;
	mode_t           current_mode;
	logic [XLEN-1:0] trap_pc;
	logic            irq_request;
	logic [XLEN-1:0] irq_cause;

	int              cycles = 0;
	int              checks = 0;
	int              errors = 0;
	int              test_num = 0;
	int              errors_at_start = 0;
	int              waited;
	logic [XLEN-1:0] rd;
	logic [XLEN-1:0] mvec;
	logic [XLEN-1:0] svec;
	logic [XLEN-1:0] m_epc;
	logic [XLEN-1:0] pc;

	priv_csr_top i_priv_csr_top (
		.clk               (clk),
		.nrst              (nrst),
		.csr_op            (csr_op),
		.csr_addr          (csr_addr),
		.csr_src           (csr_src),
		.exception_pending (exception_pending),
		.cause             (cause),
		.pc_exc            (pc_exc),
		.m_ret             (m_ret),
		.s_ret             (s_ret),
		.ext_m_irq         (ext_m_irq),
		.ext_s_irq         (ext_s_irq),
		.csr_rdata         (csr_rdata),
		.current_mode      (current_mode),
		.trap_pc           (trap_pc),
		.irq_request       (irq_request),
		.irq_cause         (irq_cause)
	);

	bind priv_csr_top priv_csr_properties i_priv_csr_properties (
		.clk               (clk),
		.nrst              (nrst),
		.exception_pending (exception_pending),
		.m_ret             (m_ret),
		.s_ret             (s_ret),
		.current_mode      (current_mode),
		.irq_request       (irq_request),
		.mie               (mie)
	);

	initial clk = 1'b0;

	always #50 clk = ~clk;

	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES)
		begin
			$display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
			$display("Done: errors found");
			$finish;
		end
	end

	// inputs change 5 ns after the edge
	task automatic next_cycle();
		@(posedge clk);
		#5;
	endtask

	task automatic check(input string name, input logic [XLEN-1:0] actual,
			input logic [XLEN-1:0] expected);
		checks++;
		assert (actual === expected)
		else
		begin
			$display("FAILED %s: expected %h, actual %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic finish_test(input string name);
		test_num++;
		$display("test %0d %s finished with %0d errors", test_num, name,
			errors - errors_at_start);
		errors_at_start = errors;
	endtask

	// old value sampled at the falling edge and the write lands on the next rising edge
	task automatic csr_access(input csr_op_t op, input logic [11:0] addr,
			input logic [XLEN-1:0] src, output logic [XLEN-1:0] old);
		csr_op   = op;
		csr_addr = addr;
		csr_src  = src;
		@(negedge clk);
		old = csr_rdata;
		next_cycle();
		csr_op  = OP_NONE;
		csr_src = '0;
	endtask

	task automatic csr_write(input logic [11:0] addr, input logic [XLEN-1:0] value);
		logic [XLEN-1:0] unused_old;
		csr_access(OP_RW, addr, value, unused_old);
	endtask

	task automatic csr_read(input logic [11:0] addr, output logic [XLEN-1:0] value);
		csr_access(OP_NONE, addr, '0, value);
	endtask

	task automatic raise_trap(input logic [XLEN-1:0] trap_cause,
			input logic [XLEN-1:0] trap_addr, input logic [XLEN-1:0] vector);
		exception_pending = 1'b1;
		cause             = trap_cause;
		pc_exc            = trap_addr;
		@(negedge clk);
		check("trap_pc", trap_pc, vector);
		next_cycle();
		exception_pending = 1'b0;
		cause             = '0;
		pc_exc            = '0;
	endtask

	task automatic pulse_return(input logic machine, input logic [XLEN-1:0] epc);
		m_ret = machine;
		s_ret = !machine;
		@(negedge clk);
		check("trap_pc", trap_pc, epc); // return address during the pulse
		next_cycle();
		m_ret = 1'b0;
		s_ret = 1'b0;
	endtask

	// model starts from the reset value and follows each operation
	task automatic csr_ops_test(input logic [11:0] addr, input logic [XLEN-1:0] mask,
			input string name);
		logic [XLEN-1:0] model;
		logic [XLEN-1:0] src;
		logic [XLEN-1:0] old;
		model = '0;
		src = $urandom;
		csr_access(OP_RW, addr, src, old);
		check({"csr_rdata ", name}, old, model);
		model = src & mask;
		src = $urandom;
		csr_access(OP_RS, addr, src, old);
		check({"csr_rdata ", name}, old, model);
		model = (model | src) & mask;
		src = $urandom;
		csr_access(OP_RC, addr, src, old);
		check({"csr_rdata ", name}, old, model);
		model = model & ~src;
		csr_access(OP_RS, addr, '0, old); // zero source leaves the value alone
		check({"csr_rdata ", name}, old, model);
		csr_read(addr, old);
		check({"csr_rdata ", name}, old, model);
	endtask

	initial
	begin
		void'($urandom(32'ha95d_d5e1));
		nrst              = 1'b0;
		csr_op            = OP_NONE;
		csr_addr          = '0;
		csr_src           = '0;
		exception_pending = 1'b0;
		cause             = '0;
		pc_exc            = '0;
		m_ret             = 1'b0;
		s_ret             = 1'b0;
		ext_m_irq         = 1'b0;
		ext_s_irq         = 1'b0;
		repeat (5) @(posedge clk);
		#5;
		nrst = 1'b1;

		check("current_mode", 32'(current_mode), 32'(M));
		check("irq_request", 32'(irq_request), '0);
		csr_read(CSR_MSTATUS, rd);
		check("mstatus", rd, 32'h0000_1800); // mpp = M and enables clear
		csr_read(CSR_MIE, rd);
		check("mie", rd, '0);
		csr_read(CSR_MISA, rd);
		check("misa", rd, (32'd1 << 30) | (32'd1 << 18) | (32'd1 << 8));
		finish_test("reset state");

		csr_ops_test(CSR_MSCRATCH, 32'hffff_ffff, "mscratch");
		csr_ops_test(CSR_STVEC, 32'hffff_fffc, "stvec");
		finish_test("csr operations");

		mvec = $urandom & 32'hffff_fffc;
		csr_write(CSR_MTVEC, mvec);
		m_epc = $urandom & 32'hffff_fffc;
		csr_write(CSR_MEPC, m_epc);
		csr_write(CSR_MSTATUS, 32'h0000_0880); // mpp = S and mpie set
		pulse_return(1'b1, m_epc);
		check("current_mode", 32'(current_mode), 32'(S));
		csr_read(CSR_MSTATUS, rd);
		check("mstatus", rd, 32'h0000_0088);
		csr_access(OP_RC, CSR_MSTATUS, 32'd1 << 3, rd); // mie low while mpie stays high
		pc = $urandom;
		raise_trap({1'b0, EXC_ILLEGAL}, pc, mvec);
		m_epc = pc & 32'hffff_fffc;
		check("current_mode", 32'(current_mode), 32'(M));
		csr_read(CSR_MEPC, rd);
		check("mepc", rd, m_epc);
		csr_read(CSR_MCAUSE, rd);
		check("mcause", rd, 32'd2);
		csr_read(CSR_MTVAL, rd);
		check("mtval", rd, '0);
		csr_read(CSR_MSTATUS, rd);
		check("mstatus", rd, 32'h0000_0800); // mpie keeps the old mie
		finish_test("undelegated trap");

		csr_write(CSR_MEDELEG, 32'd1 << 8);
		svec = $urandom & 32'hffff_fffc;
		csr_write(CSR_STVEC, svec);
		csr_write(CSR_MSTATUS, 32'h0000_0102); // mpp = U with spp and sie set
		pulse_return(1'b1, m_epc);
		check("current_mode", 32'(current_mode), 32'(U));
		pc = $urandom;
		raise_trap({1'b0, EXC_ECALL_U}, pc, svec);
		check("current_mode", 32'(current_mode), 32'(S));
		csr_read(CSR_SEPC, rd);
		check("sepc", rd, pc & 32'hffff_fffc);
		csr_read(CSR_SCAUSE, rd);
		check("scause", rd, 32'd8);
		csr_read(CSR_SSTATUS, rd);
		check("sstatus", rd, 32'h0000_0020); // spp = U
		pulse_return(1'b0, pc & 32'hffff_fffc);
		check("current_mode", 32'(current_mode), 32'(U));
		csr_read(CSR_SSTATUS, rd);
		check("sstatus", rd, 32'h0000_0022);
		pc = $urandom;
		raise_trap({1'b0, EXC_ILLEGAL}, pc, mvec); // not delegated so back to M
		m_epc = pc & 32'hffff_fffc;
		check("current_mode", 32'(current_mode), 32'(M));
		finish_test("delegated trap");

		csr_write(CSR_MTIMECMP, 32'(cycles + TIMER_AHEAD));
		csr_write(CSR_MIE, 32'd1 << IRQ_M_TIMER);
		csr_access(OP_RS, CSR_MSTATUS, 32'd1 << 3, rd);
		@(negedge clk);
		check("irq_request", 32'(irq_request), '0);
		waited = 0;
		while (irq_request !== 1'b1 && waited < IRQ_WAIT)
		begin
			@(negedge clk);
			waited++;
		end
		checks++;
		assert (irq_request === 1'b1)
		else
		begin
			$display("timer interrupt was not requested within %0d cycles", IRQ_WAIT);
			errors++;
		end
		check("irq_cause", irq_cause, 32'h8000_0000 | 32'(IRQ_M_TIMER));
		next_cycle();
		csr_access(OP_RC, CSR_MIE, 32'd1 << IRQ_M_TIMER, rd);
		@(negedge clk);
		check("irq_request", 32'(irq_request), '0);
		next_cycle();
		finish_test("timer interrupt");

		csr_write(CSR_MSTATUS, 32'h0000_0800); // mpp = S with all enables clear
		csr_write(CSR_MIE, (32'd1 << IRQ_M_EXT) | (32'd1 << IRQ_S_EXT));
		pulse_return(1'b1, m_epc);
		check("current_mode", 32'(current_mode), 32'(S));
		ext_m_irq = 1'b1;
		ext_s_irq = 1'b1;
		@(negedge clk);
		check("irq_request", 32'(irq_request), 32'd1);
		check("irq_cause", irq_cause, 32'h8000_0000 | 32'(IRQ_M_EXT));
		next_cycle();
		ext_m_irq = 1'b0;
		csr_write(CSR_MIDELEG, 32'd1 << IRQ_S_EXT);
		@(negedge clk);
		check("irq_request", 32'(irq_request), '0); // sie still clear
		next_cycle();
		csr_access(OP_RS, CSR_SSTATUS, 32'd1 << 1, rd);
		@(negedge clk);
		check("irq_request", 32'(irq_request), 32'd1);
		check("irq_cause", irq_cause, 32'h8000_0000 | 32'(IRQ_S_EXT));
		next_cycle();
		ext_s_irq = 1'b0;
		finish_test("external priority");

		errors = errors + i_priv_csr_top.i_priv_csr_properties.fail_count;
		$display("tests %0d, checks %0d, errors %0d (property failures %0d)", test_num,
			checks, errors, i_priv_csr_top.i_priv_csr_properties.fail_count);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
rtl/csr_pkg.sv
rtl/csr_op_unit.sv
rtl/csr_regfile.sv
rtl/csr_timer.sv
rtl/irq_select.sv
rtl/priv_csr_top.sv
bench/priv_csr_properties.sv
bench/tb_priv_csr.sv

// File: rtl/csr_op_unit.sv
`timescale 1ns/1ps
`default_nettype none

module csr_op_unit
	import csr_pkg::*;
(
	input  csr_op_t         csr_op,
	input  logic [XLEN-1:0] csr_src,
	input  logic [XLEN-1:0] old_value,
	output logic [XLEN-1:0] wr_value,
	output logic            wr_en
);

	always_comb
	begin
		wr_value = old_value;
		wr_en    = 1'b0;
		case (csr_op)
			OP_RW:
			begin
				wr_value = csr_src;
				wr_en    = 1'b1;
			end
			OP_RS:
			begin
				wr_value = old_value | csr_src;
				wr_en    = |csr_src; // rs1 = x0 is a pure read
			end
			OP_RC:
			begin
				wr_value = old_value & ~csr_src;
				wr_en    = |csr_src;
			end
			default: ; // no access this cycle
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/csr_pkg.sv
`default_nettype none

package csr_pkg;

	typedef enum logic [1:0] {
		U = 2'd0,
		S = 2'd1,
		M = 2'd3
	} mode_t;

	// low two bits of the csr funct3 field
	typedef enum logic [1:0] {
		OP_NONE = 2'd0,
		OP_RW   = 2'd1,
		OP_RS   = 2'd2,
		OP_RC   = 2'd3
	} csr_op_t;

	localparam int XLEN = 32;

	localparam logic [11:0] CSR_MSTATUS  = 12'h300;
	localparam logic [11:0] CSR_MISA     = 12'h301;
	localparam logic [11:0] CSR_MEDELEG  = 12'h302;
	localparam logic [11:0] CSR_MIDELEG  = 12'h303;
	localparam logic [11:0] CSR_MIE      = 12'h304;
	localparam logic [11:0] CSR_MTVEC    = 12'h305;
	localparam logic [11:0] CSR_MSCRATCH = 12'h340;
	localparam logic [11:0] CSR_MEPC     = 12'h341;
	localparam logic [11:0] CSR_MCAUSE   = 12'h342;
	localparam logic [11:0] CSR_MTVAL    = 12'h343;
	localparam logic [11:0] CSR_MIP      = 12'h344;
	localparam logic [11:0] CSR_MTIMECMP = 12'h7c0; // custom, low word only

	localparam logic [11:0] CSR_SSTATUS  = 12'h100;
	localparam logic [11:0] CSR_SIE      = 12'h104;
	localparam logic [11:0] CSR_STVEC    = 12'h105;
	localparam logic [11:0] CSR_SSCRATCH = 12'h140;
	localparam logic [11:0] CSR_SEPC     = 12'h141;
	localparam logic [11:0] CSR_SCAUSE   = 12'h142;
	localparam logic [11:0] CSR_STVAL    = 12'h143;
	localparam logic [11:0] CSR_SIP      = 12'h144;
	localparam logic [11:0] CSR_STIMECMP = 12'h5c0;

	// mxl = 1, extensions I and S
	localparam logic [XLEN-1:0] MISA_VALUE = 32'h4004_0100;

	// mstatus field positions, mpp sits at 12:11
	localparam int MS_SIE  = 1;
	localparam int MS_MIE  = 3;
	localparam int MS_SPIE = 5;
	localparam int MS_MPIE = 7;
	localparam int MS_SPP  = 8;

	localparam logic [XLEN-1:0] SSTATUS_MASK = 32'h0000_0122; // sie, spie, spp
	localparam logic [XLEN-1:0] S_IRQ_MASK   = 32'h0000_0220; // stimer, sext

	localparam logic [XLEN-2:0] EXC_I_MISALIGNED = 31'd0;
	localparam logic [XLEN-2:0] EXC_ILLEGAL      = 31'd2;
	localparam logic [XLEN-2:0] EXC_ECALL_U      = 31'd8;
	localparam logic [XLEN-2:0] EXC_ECALL_S      = 31'd9;

	localparam int IRQ_S_TIMER = 5;
	localparam int IRQ_M_TIMER = 7;
	localparam int IRQ_S_EXT   = 9;
	localparam int IRQ_M_EXT   = 11;

endpackage

`default_nettype wire

// File: rtl/csr_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module csr_regfile
	import csr_pkg::*;
(
	input  logic            clk,
	input  logic            nrst,
	input  logic [11:0]     csr_addr,
	input  logic [XLEN-1:0] wr_value,
	input  logic            wr_en,
	input  logic            exception_pending,
	input  logic [XLEN-1:0] cause,
	input  logic [XLEN-1:0] pc_exc,
	input  logic            m_ret,
	input  logic            s_ret,
	input  logic            m_timer,
	input  logic            s_timer,
	input  logic            ext_m_irq,
	input  logic            ext_s_irq,
	output logic [XLEN-1:0] rd_value,
	output logic [63:0]     mtimecmp,
	output logic [63:0]     stimecmp,
	output logic [XLEN-1:0] mip,
	output logic [XLEN-1:0] mie,
	output logic [11:0]     mideleg,
	output logic            status_mie,
	output logic            status_sie,
	output mode_t           current_mode,
	output logic [XLEN-1:0] trap_pc
);

	logic            status_mpie;
	logic            status_spie;
	logic            status_spp;
	mode_t           status_mpp;
	logic            meie;
	logic            seie;
	logic            mtie;
	logic            stie;
	logic [XLEN-1:2] mtvec; // direct mode only
	logic [XLEN-1:2] stvec;
	logic [XLEN-1:2] mepc;
	logic [XLEN-1:2] sepc;
	logic [XLEN-1:0] mscratch;
	logic [XLEN-1:0] sscratch;
	logic [XLEN-1:0] mcause;
	logic [XLEN-1:0] scause;
	logic [XLEN-1:0] mtval;
	logic [XLEN-1:0] stval;
	logic [15:0]     medeleg;
	logic [XLEN-1:0] mtimecmp_lo;
	logic [XLEN-1:0] stimecmp_lo;
	logic [XLEN-1:0] mstatus;
	logic            deleg_hit;
	mode_t           trap_mode;
	logic [XLEN-1:0] trap_tval;
	mode_t           mpp_wr;

	assign mtimecmp = {32'b0, mtimecmp_lo};
	assign stimecmp = {32'b0, stimecmp_lo};

	always_comb
	begin
		mstatus = '0;
		mstatus[MS_SIE]  = status_sie;
		mstatus[MS_MIE]  = status_mie;
		mstatus[MS_SPIE] = status_spie;
		mstatus[MS_MPIE] = status_mpie;
		mstatus[MS_SPP]  = status_spp;
		mstatus[12:11]   = status_mpp;

		mie = '0;
		mie[IRQ_S_TIMER] = stie;
		mie[IRQ_M_TIMER] = mtie;
		mie[IRQ_S_EXT]   = seie;
		mie[IRQ_M_EXT]   = meie;

		// pending bits come straight from the sources
		mip = '0;
		mip[IRQ_S_TIMER] = s_timer;
		mip[IRQ_M_TIMER] = m_timer;
		mip[IRQ_S_EXT]   = ext_s_irq;
		mip[IRQ_M_EXT]   = ext_m_irq;
	end

	// target mode of a trap raised this cycle
	always_comb
	begin
		if (cause[XLEN-1])
			deleg_hit = (cause[XLEN-2:0] < 31'd12) && mideleg[cause[3:0]];
		else
			deleg_hit = (cause[XLEN-2:0] < 31'd16) && medeleg[cause[3:0]];
		if (current_mode == M || !deleg_hit)
			trap_mode = M;
		else
			trap_mode = S;
	end

	assign trap_tval = (!cause[XLEN-1] && cause[XLEN-2:0] == EXC_I_MISALIGNED) ? pc_exc : '0;
	assign mpp_wr    = (wr_value[12:11] == 2'b10) ? U : mode_t'(wr_value[12:11]); // 2 is reserved

	always_comb
	begin
		if (m_ret)
			trap_pc = {mepc, 2'b00};
		else if (s_ret)
			trap_pc = {sepc, 2'b00};
		else if (trap_mode == S)
			trap_pc = {stvec, 2'b00};
		else
			trap_pc = {mtvec, 2'b00};
	end

	always_comb
	begin
		case (csr_addr)
			CSR_MSTATUS:  rd_value = mstatus;
			CSR_MISA:     rd_value = MISA_VALUE;
			CSR_MEDELEG:  rd_value = {16'b0, medeleg};
			CSR_MIDELEG:  rd_value = {20'b0, mideleg};
			CSR_MIE:      rd_value = mie;
			CSR_MTVEC:    rd_value = {mtvec, 2'b00};
			CSR_MSCRATCH: rd_value = mscratch;
			CSR_MEPC:     rd_value = {mepc, 2'b00};
			CSR_MCAUSE:   rd_value = mcause;
			CSR_MTVAL:    rd_value = mtval;
			CSR_MIP:      rd_value = mip;
			CSR_MTIMECMP: rd_value = mtimecmp_lo;
			CSR_SSTATUS:  rd_value = mstatus & SSTATUS_MASK;
			CSR_SIE:      rd_value = mie & S_IRQ_MASK;
			CSR_STVEC:    rd_value = {stvec, 2'b00};
			CSR_SSCRATCH: rd_value = sscratch;
			CSR_SEPC:     rd_value = {sepc, 2'b00};
			CSR_SCAUSE:   rd_value = scause;
			CSR_STVAL:    rd_value = stval;
			CSR_SIP:      rd_value = mip & S_IRQ_MASK;
			CSR_STIMECMP: rd_value = stimecmp_lo;
			default:      rd_value = '0;
		endcase
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			current_mode <= M;
			status_mie   <= 1'b0;
			status_sie   <= 1'b0;
			status_mpie  <= 1'b0;
			status_spie  <= 1'b0;
			status_spp   <= 1'b0;
			status_mpp   <= M;
			meie         <= 1'b0;
			seie         <= 1'b0;
			mtie         <= 1'b0;
			stie         <= 1'b0;
			mtvec        <= '0;
			stvec        <= '0;
			mepc         <= '0;
			sepc         <= '0;
			mscratch     <= '0;
			sscratch     <= '0;
			mcause       <= '0;
			scause       <= '0;
			mtval        <= '0;
			stval        <= '0;
			medeleg      <= '0;
			mideleg      <= '0;
			mtimecmp_lo  <= '0;
			stimecmp_lo  <= '0;
		end
		else
		begin
			if (wr_en && !exception_pending)
			begin
				case (csr_addr)
					CSR_MSTATUS:
					begin
						status_sie  <= wr_value[MS_SIE];
						status_mie  <= wr_value[MS_MIE];
						status_spie <= wr_value[MS_SPIE];
						status_mpie <= wr_value[MS_MPIE];
						status_spp  <= wr_value[MS_SPP];
						status_mpp  <= mpp_wr;
					end
					CSR_SSTATUS:
					begin
						status_sie  <= wr_value[MS_SIE];
						status_spie <= wr_value[MS_SPIE];
						status_spp  <= wr_value[MS_SPP];
					end
					CSR_MIE:
					begin
						stie <= wr_value[IRQ_S_TIMER];
						mtie <= wr_value[IRQ_M_TIMER];
						seie <= wr_value[IRQ_S_EXT];
						meie <= wr_value[IRQ_M_EXT];
					end
					CSR_SIE:
					begin
						stie <= wr_value[IRQ_S_TIMER];
						seie <= wr_value[IRQ_S_EXT];
					end
					CSR_MEDELEG:  medeleg     <= wr_value[15:0];
					CSR_MIDELEG:  mideleg     <= wr_value[11:0];
					CSR_MTVEC:    mtvec       <= wr_value[XLEN-1:2];
					CSR_STVEC:    stvec       <= wr_value[XLEN-1:2];
					CSR_MSCRATCH: mscratch    <= wr_value;
					CSR_SSCRATCH: sscratch    <= wr_value;
					CSR_MEPC:     mepc        <= wr_value[XLEN-1:2];
					CSR_SEPC:     sepc        <= wr_value[XLEN-1:2];
					CSR_MCAUSE:   mcause      <= wr_value;
					CSR_SCAUSE:   scause      <= wr_value;
					CSR_MTVAL:    mtval       <= wr_value;
					CSR_STVAL:    stval       <= wr_value;
					CSR_MTIMECMP: mtimecmp_lo <= wr_value;
					CSR_STIMECMP: stimecmp_lo <= wr_value;
					default: ; // mip, sip and misa are read only
				endcase
			end

			if (exception_pending)
			begin
				current_mode <= trap_mode;
				if (trap_mode == M)
				begin
					mepc        <= pc_exc[XLEN-1:2];
					mcause      <= cause;
					mtval       <= trap_tval;
					status_mpie <= status_mie;
					status_mpp  <= current_mode;
					status_mie  <= 1'b0;
				end
				else
				begin
					sepc        <= pc_exc[XLEN-1:2];
					scause      <= cause;
					stval       <= trap_tval;
					status_spie <= status_sie;
					status_spp  <= current_mode[0]; // U or S only here
					status_sie  <= 1'b0;
				end
			end
			else if (m_ret)
			begin
				current_mode <= status_mpp;
				status_mie   <= status_mpie;
				status_mpie  <= 1'b1;
				status_mpp   <= U;
			end
			else if (s_ret)
			begin
				current_mode <= status_spp ? S : U;
				status_sie   <= status_spie;
				status_spie  <= 1'b1;
				status_spp   <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/csr_timer.sv
`timescale 1ns/1ps
`default_nettype none

module csr_timer
(
	input  logic        clk,
	input  logic        nrst,
	input  logic [63:0] mtimecmp,
	input  logic [63:0] stimecmp,
	output logic        m_timer,
	output logic        s_timer
);

	logic [63:0] mtime;

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			mtime   <= '0;
			m_timer <= 1'b0;
			s_timer <= 1'b0;
		end
		else
		begin
			mtime   <= mtime + 64'd1; // free running, wraps
			m_timer <= (mtime >= mtimecmp);
			s_timer <= (mtime >= stimecmp);
		end
	end

endmodule

`default_nettype wire

// File: rtl/irq_select.sv
`timescale 1ns/1ps
`default_nettype none

module irq_select
	import csr_pkg::*;
(
	input  logic [XLEN-1:0] mip,
	input  logic [XLEN-1:0] mie,
	input  logic [11:0]     mideleg,
	input  logic            status_mie,
	input  logic            status_sie,
	input  mode_t           current_mode,
	output logic            irq_request,
	output logic [XLEN-1:0] irq_cause
);

	logic [XLEN-1:0] pending;
	logic            take_m_ext;
	logic            take_m_timer;
	logic            take_s_ext;
	logic            take_s_timer;

	// target from mideleg, then compare against the running mode
	function automatic logic can_take(input logic pend, input logic deleg, input mode_t cur,
			input logic mie_g, input logic sie_g);
		mode_t target;
		logic  glob;
		target = deleg ? S : M;
		glob   = (target == M) ? mie_g : sie_g;
		return pend && ((target > cur) || (target == cur && glob));
	endfunction

	assign pending = mip & mie;

	assign take_m_ext   = can_take(pending[IRQ_M_EXT], mideleg[IRQ_M_EXT], current_mode,
			status_mie, status_sie);
	assign take_m_timer = can_take(pending[IRQ_M_TIMER], mideleg[IRQ_M_TIMER], current_mode,
			status_mie, status_sie);
	assign take_s_ext   = can_take(pending[IRQ_S_EXT], mideleg[IRQ_S_EXT], current_mode,
			status_mie, status_sie);
	assign take_s_timer = can_take(pending[IRQ_S_TIMER], mideleg[IRQ_S_TIMER], current_mode,
			status_mie, status_sie);

	always_comb
	begin
		irq_request = 1'b1;
		irq_cause   = '0;
		if (take_m_ext)
			irq_cause = {1'b1, 31'(IRQ_M_EXT)};
		else if (take_m_timer)
			irq_cause = {1'b1, 31'(IRQ_M_TIMER)};
		else if (take_s_ext)
			irq_cause = {1'b1, 31'(IRQ_S_EXT)};
		else if (take_s_timer)
			irq_cause = {1'b1, 31'(IRQ_S_TIMER)};
		else
			irq_request = 1'b0;
	end

endmodule

`default_nettype wire

// File: rtl/priv_csr_top.sv
`timescale 1ns/1ps
`default_nettype none

module priv_csr_top
	import csr_pkg::*;
(
	input  logic            clk,
	input  logic            nrst,
	input  csr_op_t         csr_op,
	input  logic [11:0]     csr_addr,
	input  logic [XLEN-1:0] csr_src,
	input  logic            exception_pending,
	input  logic [XLEN-1:0] cause,
	input  logic [XLEN-1:0] pc_exc,
	input  logic            m_ret,
	input  logic            s_ret,
	input  logic            ext_m_irq,
	input  logic            ext_s_irq,
	output logic [XLEN-1:0] csr_rdata,
	output mode_t           current_mode,
	output logic [XLEN-1:0] trap_pc,
	output logic            irq_request,
	output logic [XLEN-1:0] irq_cause
);

	logic [XLEN-1:0] wr_value;
	logic            wr_en;
	logic [63:0]     mtimecmp;
	logic [63:0]     stimecmp;
	logic            m_timer;
	logic            s_timer;
	logic [XLEN-1:0] mip;
	logic [XLEN-1:0] mie;
	logic [11:0]     mideleg;
	logic            status_mie;
	logic            status_sie;

	// old value feeds back into the operation unit
	csr_op_unit i_csr_op_unit (
		.csr_op    (csr_op),
		.csr_src   (csr_src),
		.old_value (csr_rdata),
		.wr_value  (wr_value),
		.wr_en     (wr_en)
	);

	csr_regfile i_csr_regfile (
		.clk               (clk),
		.nrst              (nrst),
		.csr_addr          (csr_addr),
		.wr_value          (wr_value),
		.wr_en             (wr_en),
		.exception_pending (exception_pending),
		.cause             (cause),
		.pc_exc            (pc_exc),
		.m_ret             (m_ret),
		.s_ret             (s_ret),
		.m_timer           (m_timer),
		.s_timer           (s_timer),
		.ext_m_irq         (ext_m_irq),
		.ext_s_irq         (ext_s_irq),
		.rd_value          (csr_rdata),
		.mtimecmp          (mtimecmp),
		.stimecmp          (stimecmp),
		.mip               (mip),
		.mie               (mie),
		.mideleg           (mideleg),
		.status_mie        (status_mie),
		.status_sie        (status_sie),
		.current_mode      (current_mode),
		.trap_pc           (trap_pc)
	);

	csr_timer i_csr_timer (
		.clk      (clk),
		.nrst     (nrst),
		.mtimecmp (mtimecmp),
		.stimecmp (stimecmp),
		.m_timer  (m_timer),
		.s_timer  (s_timer)
	);

	irq_select i_irq_select (
		.mip          (mip),
		.mie          (mie),
		.mideleg      (mideleg),
		.status_mie   (status_mie),
		.status_sie   (status_sie),
		.current_mode (current_mode),
		.irq_request  (irq_request),
		.irq_cause    (irq_cause)
	);

endmodule

`default_nettype wire
